// ==== logic/div_pkg.sv ====
// divide unit shared definitions
// operand width, function encoding and the packed payloads between stages
`default_nettype none

package div_pkg;

  // operand width, iteration count follows from it
  localparam int DIV_W = 32;

  // request function
  typedef enum logic [0:0] {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  // ------------------------------
  // stage payloads
  // ------------------------------

  // incoming request, 65 bits
  typedef struct packed {
    div_fn_e          fn;
    logic [DIV_W-1:0] a;
    logic [DIV_W-1:0] b;
  } div_req_t;

  // magnitudes plus result sign flags, 66 bits
  typedef struct packed {
    logic [DIV_W-1:0] dividend_mag;
    logic [DIV_W-1:0] divisor_mag;
    logic             quot_neg;
    logic             rem_neg;
  } div_operands_t;

  // unsigned core result, flags ride along, 66 bits
  typedef struct packed {
    logic [DIV_W-1:0] quotient;
    logic [DIV_W-1:0] remainder;
    logic             quot_neg;
    logic             rem_neg;
  } div_raw_t;

  // response, remainder in the upper half
  typedef struct packed {
    logic [DIV_W-1:0] remainder;
    logic [DIV_W-1:0] quotient;
  } div_resp_t;

endpackage

`default_nettype wire

// ==== logic/div_operand_prep.sv ====
// divide input stage
// one-entry request buffer holding operand magnitudes and result sign flags
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  output logic                  req_rdy,
  input  div_pkg::div_req_t     req,
  output logic                  ops_val,
  input  logic                  ops_rdy,
  output div_pkg::div_operands_t ops
);

  // ------------------------------
  // operand conditioning
  // ------------------------------

  logic                   is_signed;
  logic                   a_neg;
  logic                   b_neg;
  div_pkg::div_operands_t ops_next;

  assign is_signed = (req.fn == div_pkg::DIV_SIGNED);
  assign a_neg     = is_signed && req.a[div_pkg::DIV_W-1];
  assign b_neg     = is_signed && req.b[div_pkg::DIV_W-1];

  // two's complement magnitude only for negative signed operands
  assign ops_next.dividend_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign ops_next.divisor_mag  = b_neg ? (~req.b + 1'b1) : req.b;
  // divide by zero keeps the all-ones quotient unnegated
  assign ops_next.quot_neg     = (a_neg ^ b_neg) && (req.b != '0);
  // remainder follows the dividend sign
  assign ops_next.rem_neg      = a_neg;

  // ------------------------------
  // one-entry buffer
  // ------------------------------

  // free when empty or draining this cycle
  assign req_rdy = !ops_val || ops_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      ops_val <= 1'b0;
    end else if (req_val && req_rdy) begin
      ops_val <= 1'b1;
    end else if (ops_rdy) begin
      ops_val <= 1'b0;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      ops <= ops_next;
    end
  end

  // held item must not change while the core is busy
  ops_hold_a : assert property (@(posedge clk) disable iff (reset)
    ops_val && !ops_rdy |=> ops_val && $stable(ops));

endmodule

`default_nettype wire

// ==== logic/div_iter_ctrl.sv ====
// divide core control
// IDLE/CALC/DONE sequencing and the quotient-bit counter
`timescale 1ns/1ps
`default_nettype none

module div_iter_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic ops_val,
  output logic ops_rdy,
  output logic raw_val,
  input  logic raw_rdy,
  input  logic sub_neg,
  output logic load,
  output logic step,
  output logic keep_diff
);

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e     state;
  logic [4:0] count;
  logic       count_zero;

  assign count_zero = (count == 5'd0);

  // ------------------------------
  // handshake and datapath control
  // ------------------------------

  // ready depends on state only
  assign ops_rdy   = (state == IDLE);
  assign load      = ops_rdy && ops_val;
  // one quotient bit per CALC cycle
  assign step      = (state == CALC);
  // trial difference non-negative means quotient bit 1
  assign keep_diff = ~sub_neg;
  assign raw_val   = (state == DONE);

  // ------------------------------
  // state and counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= 5'd0;
    end else begin
      case (state)
        IDLE: begin
          if (load) begin
            state <= CALC;
            count <= 5'(div_pkg::DIV_W - 1);
          end
        end
        CALC: begin
          // last bit done on the zero count
          if (count_zero) begin
            state <= DONE;
          end else begin
            count <= count - 5'd1;
          end
        end
        DONE: begin
          if (raw_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // exactly DIV_W steps before the result is offered
  calc_len_a : assert property (@(posedge clk) disable iff (reset)
    (state == CALC) && !count_zero |=> (state == CALC));

  // result rises exactly DIV_W + 1 edges after the load
  raw_val_done_a : assert property (@(posedge clk) disable iff (reset)
    $rose(raw_val) |-> $past(load, div_pkg::DIV_W + 1));

endmodule

`default_nettype wire

// ==== logic/div_iter_dpath.sv ====
// divide core datapath
// restoring shift-subtract over a joint remainder/quotient register
`timescale 1ns/1ps
`default_nettype none

module div_iter_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  div_pkg::div_operands_t ops,
  input  logic                   load,
  input  logic                   step,
  input  logic                   keep_diff,
  output logic                   sub_neg,
  output div_pkg::div_raw_t      raw
);

  localparam int W    = div_pkg::DIV_W;
  // remainder in the upper part, quotient shifts in from the bottom
  localparam int RQ_W = 2 * W + 1;

  logic [RQ_W-1:0] rq;
  // divisor aligned to the remainder half
  logic [RQ_W-1:0] dvsr;
  logic            quot_neg;
  logic            rem_neg;

  logic [RQ_W-1:0] shifted;
  logic [RQ_W-1:0] diff;
  logic [RQ_W-1:0] rq_next;

  // ------------------------------
  // shift-subtract step
  // ------------------------------

  assign shifted = rq << 1;
  assign diff    = shifted - dvsr;
  // top bit set means divisor did not fit
  assign sub_neg = diff[RQ_W-1];

  // keep the difference with bit 1, or restore with bit 0
  assign rq_next = keep_diff ? {diff[RQ_W-1:1], 1'b1}
                             : {shifted[RQ_W-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (load) begin
      rq   <= {{(W+1){1'b0}}, ops.dividend_mag};
      dvsr <= {1'b0, ops.divisor_mag, {W{1'b0}}};
    end else if (step) begin
      rq <= rq_next;
    end
  end

  // sign flags captured with the operands
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (load) begin
      quot_neg <= ops.quot_neg;
      rem_neg  <= ops.rem_neg;
    end
  end

  // ------------------------------
  // result straight from the registers
  // ------------------------------

  assign raw.quotient  = rq[W-1:0];
  assign raw.remainder = rq[2*W-1:W];
  assign raw.quot_neg  = quot_neg;
  assign raw.rem_neg   = rem_neg;

endmodule

`default_nettype wire

// ==== logic/div_result_fixup.sv ====
// divide output stage
// restores result signs and holds the response under back-pressure
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup (
  input  logic               clk,
  input  logic               reset,
  input  logic               raw_val,
  output logic               raw_rdy,
  input  div_pkg::div_raw_t  raw,
  output logic               resp_val,
  input  logic               resp_rdy,
  output div_pkg::div_resp_t resp
);

  div_pkg::div_resp_t resp_next;

  // ------------------------------
  // sign restore
  // ------------------------------

  assign resp_next.quotient  = raw.quot_neg ? (~raw.quotient + 1'b1) : raw.quotient;
  assign resp_next.remainder = raw.rem_neg ? (~raw.remainder + 1'b1) : raw.remainder;

  // ------------------------------
  // response register
  // ------------------------------

  // accept when empty or when the held response leaves this cycle
  assign raw_rdy = !resp_val || resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (raw_val && raw_rdy) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (raw_val && raw_rdy) begin
      resp <= resp_next;
    end
  end

  // outside stall freezes the response
  resp_hold_a : assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp));

endmodule

`default_nettype wire

// ==== logic/div_unit.sv ====
// iterative 32-bit divide unit
// input buffer, shift-subtract core and response register in a val/rdy chain
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  div_pkg::div_req_t  req,
  output logic               resp_val,
  input  logic               resp_rdy,
  output div_pkg::div_resp_t resp
);

  // input side to core
  logic                   ops_val;
  logic                   ops_rdy;
  div_pkg::div_operands_t ops;

  // core to output side
  logic                   raw_val;
  logic                   raw_rdy;
  div_pkg::div_raw_t      raw;

  // core internals
  logic                   load;
  logic                   step;
  logic                   keep_diff;
  logic                   sub_neg;

  // ------------------------------
  // stages
  // ------------------------------

  div_operand_prep u_prep (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req     (req),
    .ops_val (ops_val),
    .ops_rdy (ops_rdy),
    .ops     (ops)
  );

  div_iter_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .ops_val   (ops_val),
    .ops_rdy   (ops_rdy),
    .raw_val   (raw_val),
    .raw_rdy   (raw_rdy),
    .sub_neg   (sub_neg),
    .load      (load),
    .step      (step),
    .keep_diff (keep_diff)
  );

  div_iter_dpath u_dpath (
    .clk       (clk),
    .reset     (reset),
    .ops       (ops),
    .load      (load),
    .step      (step),
    .keep_diff (keep_diff),
    .sub_neg   (sub_neg),
    .raw       (raw)
  );

  div_result_fixup u_fixup (
    .clk      (clk),
    .reset    (reset),
    .raw_val  (raw_val),
    .raw_rdy  (raw_rdy),
    .raw      (raw),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

endmodule

`default_nettype wire

// ==== bench/div_unit_tb.sv ====
// testbench for the iterative divide unit
// replays vectors from the data file under random response back-pressure
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;

  localparam int MAX_VEC   = 64;
  localparam int VEC_WORDS = 5;
  localparam int MEM_WORDS = 1 + MAX_VEC * VEC_WORDS;
  // edges from request acceptance to the response transfer, resp_rdy held high
  localparam int FIRST_LATENCY = 35;
  // quiet cycles after the last response, nothing may show up
  localparam int IDLE_CYCLES = 40;

  logic               clk;
  logic               reset;
  logic               req_val;
  logic               req_rdy;
  div_pkg::div_req_t  req;
  logic               resp_val;
  logic               resp_rdy;
  div_pkg::div_resp_t resp;

  // word 0 is the vector count
  // then per vector fn, dividend, divisor, quotient, remainder
  logic [31:0] vec_mem [0:MEM_WORDS-1];
  int          num_vec;
  int          send_idx;
  int          recv_idx;
  int          cycle = 0;
  int          cycle_limit = 100;
  int          accept_cycle;
  logic [31:0] rnd;

  div_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ------------------------------
  // timeout
  // ------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > cycle_limit) begin
      $display("TEST FAILED");
      $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // field k of vector idx
  function automatic logic [31:0] vec_word(input int idx, input int k);
    return vec_mem[1 + idx * VEC_WORDS + k];
  endfunction

  // payload held until req_rdy takes it
  task automatic drive_request(input int idx);
    logic [31:0] fn_word;
    fn_word = vec_word(idx, 0);
    req_val = 1'b1;
    req.fn  = div_pkg::div_fn_e'(fn_word[0]);
    req.a   = vec_word(idx, 1);
    req.b   = vec_word(idx, 2);
  endtask

  // responses arrive in request order
  task automatic check_response(input int idx);
    string name;
    name = $sformatf("vector %0d quotient", idx);
    check_value(name, vec_word(idx, 3), resp.quotient);
    name = $sformatf("vector %0d remainder", idx);
    check_value(name, vec_word(idx, 4), resp.remainder);
  endtask

  // ------------------------------
  // stimulus and checking
  // ------------------------------

  initial begin
    rnd          = $urandom(39);
    reset        = 1'b1;
    req_val      = 1'b0;
    req          = '0;
    resp_rdy     = 1'b0;
    send_idx     = 0;
    recv_idx     = 0;
    accept_cycle = 0;

    $readmemh("bench/div_testdata.txt", vec_mem);
    num_vec = int'(vec_mem[0]);
    if (num_vec < 1 || num_vec > MAX_VEC) begin
      $display("TEST FAILED");
      $fatal(1, "data file holds a vector count of %0d, outside 1 to %0d", num_vec, MAX_VEC);
    end
    // about 34 cycles per vector plus random stalls
    cycle_limit = num_vec * 200 + 100;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("reset req_rdy", 32'd1, {31'd0, req_rdy});
    check_value("reset resp_val", 32'd0, {31'd0, resp_val});

    while (recv_idx < num_vec) begin
      // first response unstalled for the latency check
      if (recv_idx == 0) begin
        resp_rdy = 1'b1;
      end else begin
        rnd      = $urandom();
        resp_rdy = rnd[0];
      end
      if (send_idx < num_vec) begin
        drive_request(send_idx);
      end else begin
        req_val = 1'b0;
        req     = '0;
      end
      // ready and valid come from registers, the next edge sees these values
      if (req_val && req_rdy) begin
        if (send_idx == 0) begin
          accept_cycle = cycle;
        end
        send_idx++;
      end
      if (resp_val && resp_rdy) begin
        if (recv_idx == 0) begin
          check_value("first vector latency", 32'(FIRST_LATENCY), 32'(cycle - accept_cycle));
        end
        check_response(recv_idx);
        recv_idx++;
      end
      @(negedge clk);
    end

    // drained, a repeated response would show here
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (IDLE_CYCLES) begin
      check_value("no extra response", 32'd0, {31'd0, resp_val});
      @(negedge clk);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_iter_ctrl.sv
logic/div_iter_dpath.sv
logic/div_result_fixup.sv
logic/div_unit.sv
bench/div_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench
# any variable can be overridden on the command line, e.g. make sim JOBS=8

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, then run from the project root so the data file path resolves
# a $fatal in the testbench gives a nonzero exit status and fails the target
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/div_testdata.txt ====
// first word: vector count, then one vector per line
// fn (0 unsigned, 1 signed) dividend divisor quotient remainder
00000019
0 00000064 00000007 0000000e 00000002
0 00000003 0000000a 00000000 00000003
0 ffffffff ffffffff 00000001 00000000
0 ffffffff 00000001 ffffffff 00000000
0 ffffffff 00000010 0fffffff 0000000f
0 80000000 00000003 2aaaaaaa 00000002
0 12345678 00001000 00012345 00000678
0 deadbeef 00010000 0000dead 0000beef
0 00000007 80000000 00000000 00000007
0 fffffffe ffffffff 00000000 fffffffe
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 fffffffd 00000005 00000000 fffffffd
1 80000000 00000002 c0000000 00000000
1 7fffffff 80000000 00000000 7fffffff
1 80000000 80000000 00000001 00000000
1 ffffffff 00000001 ffffffff 00000000
0 12345678 00000000 ffffffff 12345678
1 ffffff9c 00000000 ffffffff ffffff9c
1 00000005 00000000 ffffffff 00000005
0 00000000 00000000 ffffffff 00000000
1 80000000 ffffffff 80000000 00000000
0 80000000 ffffffff 00000000 80000000
